// File: verilog/exec_defs.svh
// Shared widths and encodings for the execute stage.
// Unit select is one-hot; conditional branch codes keep uop[4:3] == 2'b00
// and only conditional branches may use that prefix inside the CFU.
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define XLEN            32              // Data word width
`define REG_AW          5               // Register address width
`define UOP_W           5               // Micro-op width
`define FU_W            5               // Functional unit one-hot width

// Functional unit bit positions --------------------
`define FU_ALU          0
`define FU_MUL          1
`define FU_LSU          2
`define FU_CFU          3
`define FU_CSR          4

// ALU ops --------------------
`define ALU_ADD         5'd0
`define ALU_SUB         5'd1
`define ALU_XOR         5'd2
`define ALU_OR          5'd3
`define ALU_AND         5'd4
`define ALU_SLL         5'd5
`define ALU_SRL         5'd6
`define ALU_SRA         5'd7
`define ALU_SLT         5'd8
`define ALU_SLTU        5'd9            // Highest legal ALU code

// Multiplier ops
`define MUL_MUL         5'd0            // Low half
`define MUL_MULH        5'd1            // Signed x signed, high half
`define MUL_MULHSU      5'd2            // Signed x unsigned, high half
`define MUL_MULHU       5'd3            // Unsigned x unsigned, high half

// Control flow ops --------------------
`define CFU_BEQ         5'b00_001
`define CFU_BNE         5'b00_010
`define CFU_BLT         5'b00_100
`define CFU_BGE         5'b00_101
`define CFU_BLTU        5'b00_110
`define CFU_BGEU        5'b00_111
`define CFU_JAL         5'b10_000
`define CFU_JALR        5'b10_001
`define CFU_TAKEN       5'b11_000       // Resolved conditional branch
`define CFU_NOT_TAKEN   5'b11_001

// LSU micro-op flag bits
`define LSU_LOAD_BIT    3
`define LSU_STORE_BIT   4

`endif

// File: verilog/exec_pkg.sv
// Payload types for the execute stage.
// All widths come from the shared defines header.

`include "exec_defs.svh"

package exec_pkg;

    typedef logic [`XLEN-1:0]   word_t;     // One data word
    typedef logic [`UOP_W-1:0]  uop_t;      // Micro-op code
    typedef logic [`FU_W-1:0]   fu_t;       // Unit select, one-hot

    // Decode to execute --------------------
    typedef struct packed {
        logic [`REG_AW-1:0] rd;             // Destination register
        word_t              opr_a;          // rs1 value
        word_t              opr_b;          // rs2 value or immediate
        word_t              opr_c;          // Store data, CSR data, branch target
        uop_t               uop;
        fu_t                fu;
        logic               trap;           // Decode raised a trap, cause in rd
        logic [1:0]         size;           // Instruction size
        logic [31:0]        instr;          // Raw instruction word
    } ex_in_t;

    // Execute to writeback --------------------
    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        word_t              opr_a;          // Result or address
        word_t              opr_b;          // Secondary data or trap cause
        uop_t               uop;            // Branches resolved to taken/not taken
        fu_t                fu;
        logic               trap;
        logic [1:0]         size;
        logic [31:0]        instr;
    } ex_out_t;

    // Forwarding from the instruction now in execute
    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        word_t              wdata;          // Operand A as it will leave
        logic               load;           // Data not known until memory
        logic               csr;            // Data not known until CSR read
    } fwd_t;

endpackage

// File: verilog/exec_alu.sv
// Single cycle integer ALU, purely combinational.
// Also serves branch compares; unsigned compare for sltu, bltu, bgeu only.
// Shift amounts use rhs[4:0].

`include "exec_defs.svh"

module exec_alu (
    input  logic            g_clk,      // Assertion sampling only
    input  logic            g_resetn,
    input  exec_pkg::fu_t   i_fu,
    input  exec_pkg::uop_t  i_uop,
    input  exec_pkg::word_t i_lhs,
    input  exec_pkg::word_t i_rhs,
    output exec_pkg::word_t o_result,
    output exec_pkg::word_t o_sum,      // Always lhs + rhs
    output logic            o_lt,       // lhs < rhs
    output logic            o_eq        // lhs == rhs
);

    logic            fu_alu;
    logic            fu_cfu;
    logic            cmp_unsigned;
    logic [4:0]      shamt;
    exec_pkg::word_t diff;

    assign fu_alu = i_fu[`FU_ALU];
    assign fu_cfu = i_fu[`FU_CFU];
    assign shamt  = i_rhs[4:0];

    // Compare --------------------
    assign cmp_unsigned = (fu_alu && (i_uop == `ALU_SLTU)) ||
                          (fu_cfu && ((i_uop == `CFU_BLTU) || (i_uop == `CFU_BGEU)));

    assign o_lt = cmp_unsigned ? (i_lhs < i_rhs) :
                                 ($signed(i_lhs) < $signed(i_rhs));
    assign o_eq = (i_lhs == i_rhs);

    // Adder also feeds LSU address and jalr target
    assign o_sum = i_lhs + i_rhs;
    assign diff  = i_lhs - i_rhs;

    // Result mux --------------------
    always_comb begin
        case (i_uop)
            `ALU_ADD:  o_result = o_sum;
            `ALU_SUB:  o_result = diff;
            `ALU_XOR:  o_result = i_lhs ^ i_rhs;
            `ALU_OR:   o_result = i_lhs | i_rhs;
            `ALU_AND:  o_result = i_lhs & i_rhs;
            `ALU_SLL:  o_result = i_lhs << shamt;
            `ALU_SRL:  o_result = i_lhs >> shamt;
            `ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;    // Keep sign
            `ALU_SLT,
            `ALU_SLTU: o_result = {{(`XLEN-1){1'b0}}, o_lt};    // Flag, zero padded
            default:   o_result = '0;
        endcase
    end

    // Decode upstream must never hand the ALU an undefined code
    a_alu_uop_legal: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        fu_alu |-> (i_uop <= `ALU_SLTU)
    ) else $error("ALU selected with undefined uop %0d", i_uop);

endmodule

// File: verilog/exec_multiplier.sv
// Iterative 32x32 shift-add multiplier on operand magnitudes.
// First step happens on the start edge, 31 more follow, then one cycle of
// sign correction, so o_ready is high 33 cycles after a multiply is presented.
// The operation inputs must stay stable until o_ready. Flush aborts on the next edge.

`include "exec_defs.svh"

module exec_multiplier (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            i_valid,        // Multiply presented
    input  logic            i_advance,      // Result taken by the stage
    input  logic            i_flush,
    input  exec_pkg::uop_t  i_uop,
    input  exec_pkg::word_t i_rs1,
    input  exec_pkg::word_t i_rs2,
    output logic            o_ready,
    output exec_pkg::word_t o_lo,
    output exec_pkg::word_t o_hi
);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIX, S_DONE} state_t;

    state_t          state_q;
    logic [4:0]      cnt_q;             // Steps done
    logic [63:0]     prod_q;            // {partial hi, multiplier lo}
    exec_pkg::word_t mcand_q;           // Multiplicand magnitude
    logic            neg_q;             // Product must be negated

    logic            a_signed;
    logic            b_signed;
    exec_pkg::word_t a_mag;
    exec_pkg::word_t b_mag;
    logic            start;
    logic [63:0]     step_in;
    exec_pkg::word_t step_mcand;
    logic [32:0]     step_sum;          // Carry out of the add
    logic [63:0]     step_out;

    // Operand signedness --------------------
    assign a_signed = (i_uop != `MUL_MULHU);
    assign b_signed = (i_uop == `MUL_MUL) || (i_uop == `MUL_MULH);
    assign a_mag    = (a_signed && i_rs1[`XLEN-1]) ? -i_rs1 : i_rs1;
    assign b_mag    = (b_signed && i_rs2[`XLEN-1]) ? -i_rs2 : i_rs2;

    assign start = (state_q == S_IDLE) && i_valid;

    // One shift-add step, fed from the inputs on the start edge
    assign step_in    = start ? {32'b0, b_mag} : prod_q;
    assign step_mcand = start ? a_mag : mcand_q;
    assign step_sum   = {1'b0, step_in[63:32]} + (step_in[0] ? {1'b0, step_mcand} : 33'd0);
    assign step_out   = {step_sum, step_in[31:1]};

    // Control --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (i_valid) begin
                    state_q <= S_RUN;
                    cnt_q   <= 5'd1;            // Step one done on this edge
                end
                S_RUN: begin
                    cnt_q <= cnt_q + 5'd1;
                    if (cnt_q == 5'd31) state_q <= S_FIX;   // Last step now
                end
                S_FIX:  state_q <= S_DONE;
                S_DONE: if (i_advance) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start) begin
            mcand_q <= a_mag;
            neg_q   <= (a_signed && i_rs1[`XLEN-1]) ^ (b_signed && i_rs2[`XLEN-1]);
            prod_q  <= step_out;
        end else if (state_q == S_RUN) begin
            prod_q  <= step_out;
        end else if (state_q == S_FIX && neg_q) begin
            prod_q  <= -prod_q;                 // Two's complement of the 64-bit product
        end
    end

    assign o_ready = (state_q == S_DONE);
    assign o_lo    = prod_q[31:0];
    assign o_hi    = prod_q[63:32];

    // A result only appears for a multiply still being presented
    a_ready_has_valid: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        $rose(o_ready) |-> i_valid
    ) else $error("Multiplier ready without a valid multiply");

endmodule

// File: verilog/exec_result_select.sv
// Combinational result selection for the execute stage.
// Picks operand A/B per unit, resolves branches, substitutes trap cause.
// Expects fu one-hot; with no unit selected both operands read zero.

`include "exec_defs.svh"

module exec_result_select (
    input  logic              g_clk,        // Assertion sampling only
    input  logic              g_resetn,
    input  exec_pkg::ex_in_t  i_s2,
    input  exec_pkg::word_t   i_alu_result,
    input  exec_pkg::word_t   i_sum,
    input  logic              i_lt,
    input  logic              i_eq,
    input  exec_pkg::word_t   i_mul_lo,
    input  exec_pkg::word_t   i_mul_hi,
    output exec_pkg::ex_out_t o_next,
    output exec_pkg::fwd_t    o_fwd
);

    logic            fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic            cfu_cond;
    logic            taken;
    logic            lsu_store;
    exec_pkg::word_t opr_a_mul;
    exec_pkg::word_t opr_a_cfu;
    exec_pkg::word_t opr_a;
    exec_pkg::word_t opr_b;

    assign fu_alu = i_s2.fu[`FU_ALU];
    assign fu_mul = i_s2.fu[`FU_MUL];
    assign fu_lsu = i_s2.fu[`FU_LSU];
    assign fu_cfu = i_s2.fu[`FU_CFU];
    assign fu_csr = i_s2.fu[`FU_CSR];

    // Branch resolution --------------------
    assign cfu_cond = fu_cfu && (i_s2.uop[4:3] == 2'b00);
    assign taken    = (i_s2.uop == `CFU_BEQ  &&  i_eq) ||
                      (i_s2.uop == `CFU_BNE  && !i_eq) ||
                      (i_s2.uop == `CFU_BLT  &&  i_lt) ||
                      (i_s2.uop == `CFU_BGE  && !i_lt) ||
                      (i_s2.uop == `CFU_BLTU &&  i_lt) ||   // ALU compares unsigned
                      (i_s2.uop == `CFU_BGEU && !i_lt);

    assign lsu_store = fu_lsu && i_s2.uop[`LSU_STORE_BIT];

    // Operand A --------------------
    assign opr_a_mul = (i_s2.uop == `MUL_MUL) ? i_mul_lo : i_mul_hi;
    assign opr_a_cfu = (i_s2.uop == `CFU_JALR) ? {i_sum[`XLEN-1:1], 1'b0} :
                                                 {i_s2.opr_c[`XLEN-1:1], 1'b0};

    assign opr_a = ({`XLEN{fu_alu}} & i_alu_result) |
                   ({`XLEN{fu_mul}} & opr_a_mul)    |
                   ({`XLEN{fu_lsu}} & i_sum)        |   // Effective address
                   ({`XLEN{fu_cfu}} & opr_a_cfu)    |
                   ({`XLEN{fu_csr}} & i_s2.opr_a);

    // Operand B with the trap cause taking priority
    assign opr_b = i_s2.trap ? {{(`XLEN-`REG_AW){1'b0}}, i_s2.rd} :
                   (({`XLEN{fu_mul}} & i_mul_hi) |
                    ({`XLEN{lsu_store || fu_csr}} & i_s2.opr_c));

    always_comb begin
        o_next.rd    = i_s2.rd;
        o_next.opr_a = opr_a;
        o_next.opr_b = opr_b;
        o_next.uop   = cfu_cond ? (taken ? `CFU_TAKEN : `CFU_NOT_TAKEN) : i_s2.uop;
        o_next.fu    = i_s2.fu;
        o_next.trap  = i_s2.trap;
        o_next.size  = i_s2.size;
        o_next.instr = i_s2.instr;
        o_fwd.rd     = i_s2.rd;
        o_fwd.wdata  = opr_a;
        o_fwd.load   = fu_lsu && i_s2.uop[`LSU_LOAD_BIT];
        o_fwd.csr    = fu_csr;
    end

    // Any live unit select names exactly one unit
    a_fu_onehot: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        $onehot0(i_s2.fu)
    ) else $error("Unit select not one-hot: %b", i_s2.fu);

endmodule

// File: verilog/exec_pipe_reg.sv
// Output register toward writeback with valid/busy handshake.
// Holds while downstream is busy; flush drops the held entry next edge.
// No skid buffer, so o_busy follows i_busy combinationally.

`include "exec_defs.svh"

module exec_pipe_reg (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              i_flush,
    input  exec_pkg::ex_out_t i_data,
    input  logic              i_valid,
    output logic              o_busy,       // Holding and blocked
    output exec_pkg::ex_out_t o_data,
    output logic              o_valid,
    input  logic              i_busy
);

    assign o_busy = o_valid && i_busy;

    // Valid --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (!o_busy) begin
            o_valid <= i_valid;             // Load new or drain
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (i_valid && !o_busy) begin
            o_data <= i_data;
        end
    end

endmodule

// File: verilog/exec_stage.sv
// Execute stage top: ALU, multiplier, result select, output register.
// Single cycle for all units except multiply, which stalls decode
// until its result is ready. Flush kills the held output and any multiply.

`include "exec_defs.svh"

module exec_stage (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  exec_pkg::ex_in_t  i_s2,
    input  logic              i_s2_valid,
    output logic              o_s2_busy,
    input  logic              i_flush,
    output exec_pkg::fwd_t    o_fwd,
    output exec_pkg::ex_out_t o_s3,
    output logic              o_s3_valid,
    input  logic              i_s3_busy
);

    exec_pkg::word_t   alu_result;
    exec_pkg::word_t   alu_sum;
    logic              alu_lt;
    logic              alu_eq;
    logic              mul_valid;
    logic              mul_ready;
    exec_pkg::word_t   mul_lo;
    exec_pkg::word_t   mul_hi;
    exec_pkg::ex_out_t next_s3;
    logic              p_busy;          // Output register blocked
    logic              progress;        // Instruction accepted this edge

    // Stall and progress --------------------
    assign mul_valid = i_s2_valid && i_s2.fu[`FU_MUL];
    assign o_s2_busy = p_busy || (mul_valid && !mul_ready);
    assign progress  = i_s2_valid && !o_s2_busy;

    exec_alu u_alu (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_fu     (i_s2.fu),
        .i_uop    (i_s2.uop),
        .i_lhs    (i_s2.opr_a),
        .i_rhs    (i_s2.opr_b),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    exec_multiplier u_mul (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_valid   (mul_valid),
        .i_advance (progress),          // Back to idle once accepted
        .i_flush   (i_flush),
        .i_uop     (i_s2.uop),
        .i_rs1     (i_s2.opr_a),
        .i_rs2     (i_s2.opr_b),
        .o_ready   (mul_ready),
        .o_lo      (mul_lo),
        .o_hi      (mul_hi)
    );

    exec_result_select u_sel (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .i_s2         (i_s2),
        .i_alu_result (alu_result),
        .i_sum        (alu_sum),
        .i_lt         (alu_lt),
        .i_eq         (alu_eq),
        .i_mul_lo     (mul_lo),
        .i_mul_hi     (mul_hi),
        .o_next       (next_s3),
        .o_fwd        (o_fwd)
    );

    exec_pipe_reg u_preg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_data   (next_s3),
        .i_valid  (progress),
        .o_busy   (p_busy),
        .o_data   (o_s3),
        .o_valid  (o_s3_valid),
        .i_busy   (i_s3_busy)
    );

endmodule

// File: verif/tb_exec_stage.sv
// Testbench for the execute stage with random instruction streams and a model at accept.
// Inputs change 10 units after the rising edge; the model samples on the falling edge.
// Concurrent assertions compare every output transfer with the model queue head.

`include "exec_defs.svh"

module tb_exec_stage;

    localparam int MAX_INSTR     = 400;
    localparam int CYC_PER_INSTR = 40;                              // Multiply plus stalls
    localparam int TIMEOUT       = MAX_INSTR * CYC_PER_INSTR + 4000;

    logic              g_clk = 1'b0;
    logic              g_resetn;
    exec_pkg::ex_in_t  i_s2;
    logic              i_s2_valid;
    logic              o_s2_busy;
    logic              i_flush;
    exec_pkg::fwd_t    o_fwd;
    exec_pkg::ex_out_t o_s3;
    logic              o_s3_valid;
    logic              i_s3_busy;

    exec_pkg::ex_out_t exp_q[$];                                    // Accepted and not yet out
    exec_pkg::ex_out_t exp_head  = '0;
    logic              exp_empty = 1'b1;
    exec_pkg::ex_out_t rec_val   = '0;                              // Coming edge seen at negedge
    logic              rec_flush = 1'b0;
    logic              rec_pop   = 1'b0;
    logic              rec_push  = 1'b0;
    exec_pkg::fwd_t    fwd_exp;
    logic [1:0]        busy_mode = 2'd0;                            // 0 free, 1 random, 2 stuck
    int                check_errors = 0;
    int                final_errors = 0;
    int                accepted = 0;
    int                delivered = 0;
    int                dropped = 0;
    int                cycles = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                err_mark = 0;

    exec_stage UUT (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_s2(i_s2), .i_s2_valid(i_s2_valid),
        .o_s2_busy(o_s2_busy), .i_flush(i_flush), .o_fwd(o_fwd), .o_s3(o_s3),
        .o_s3_valid(o_s3_valid), .i_s3_busy(i_s3_busy)
    );

    always #50 g_clk = ~g_clk;

    // Reference model --------------------
    function automatic exec_pkg::ex_out_t expect_out(exec_pkg::ex_in_t in);
        exec_pkg::ex_out_t r;
        logic [63:0]       ea;
        logic [63:0]       eb;
        logic [63:0]       prod;
        logic              lt_s;
        logic              lt_u;
        logic              take;
        r = '{rd: in.rd, opr_a: '0, opr_b: '0, uop: in.uop, fu: in.fu, trap: in.trap,
              size: in.size, instr: in.instr};
        lt_s = $signed(in.opr_a) < $signed(in.opr_b);
        lt_u = in.opr_a < in.opr_b;
        if (in.fu[`FU_ALU]) begin
            case (in.uop)
                `ALU_ADD:  r.opr_a = in.opr_a + in.opr_b;
                `ALU_SUB:  r.opr_a = in.opr_a - in.opr_b;
                `ALU_XOR:  r.opr_a = in.opr_a ^ in.opr_b;
                `ALU_OR:   r.opr_a = in.opr_a | in.opr_b;
                `ALU_AND:  r.opr_a = in.opr_a & in.opr_b;
                `ALU_SLL:  r.opr_a = in.opr_a << in.opr_b[4:0];
                `ALU_SRL:  r.opr_a = in.opr_a >> in.opr_b[4:0];
                `ALU_SRA:  r.opr_a = $signed(in.opr_a) >>> in.opr_b[4:0];
                `ALU_SLT:  r.opr_a = {{(`XLEN-1){1'b0}}, lt_s};
                default:   r.opr_a = {{(`XLEN-1){1'b0}}, lt_u};
            endcase
        end else if (in.fu[`FU_MUL]) begin
            ea   = (in.uop == `MUL_MULHU) ? {32'b0, in.opr_a} : {{32{in.opr_a[31]}}, in.opr_a};
            eb   = (in.uop == `MUL_MULHU || in.uop == `MUL_MULHSU) ? {32'b0, in.opr_b} :
                   {{32{in.opr_b[31]}}, in.opr_b};
            prod = ea * eb;                                         // Exact low 64 bits
            r.opr_a = (in.uop == `MUL_MUL) ? prod[31:0] : prod[63:32];
            r.opr_b = prod[63:32];
        end else if (in.fu[`FU_LSU]) begin
            r.opr_a = in.opr_a + in.opr_b;
            r.opr_b = in.uop[`LSU_STORE_BIT] ? in.opr_c : '0;
        end else if (in.fu[`FU_CFU]) begin
            case (in.uop)
                `CFU_BEQ:  take = (in.opr_a == in.opr_b);
                `CFU_BNE:  take = (in.opr_a != in.opr_b);
                `CFU_BLT:  take = lt_s;
                `CFU_BGE:  take = !lt_s;
                `CFU_BLTU: take = lt_u;
                default:   take = !lt_u;
            endcase
            if (in.uop != `CFU_JAL && in.uop != `CFU_JALR) begin
                r.uop = take ? `CFU_TAKEN : `CFU_NOT_TAKEN;
            end
            r.opr_a = ((in.uop == `CFU_JALR) ? in.opr_a + in.opr_b : in.opr_c) & ~32'd1;
        end else begin
            r.opr_a = in.opr_a;                                     // CSR
            r.opr_b = in.opr_c;
        end
        if (in.trap) r.opr_b = {{(`XLEN-`REG_AW){1'b0}}, in.rd};   // Cause in rd
        return r;
    endfunction

    function automatic exec_pkg::fwd_t expect_fwd(exec_pkg::ex_in_t in);
        exec_pkg::fwd_t    f;
        exec_pkg::ex_out_t o;
        o       = expect_out(in);
        f.rd    = in.rd;
        f.wdata = o.opr_a;
        f.load  = in.fu[`FU_LSU] && in.uop[`LSU_LOAD_BIT];
        f.csr   = in.fu[`FU_CSR];
        return f;
    endfunction

    always_comb fwd_exp = expect_fwd(i_s2);

    // Apply last edge's events, then record the coming edge's
    always @(negedge g_clk) begin
        if (rec_flush) begin
            dropped += exp_q.size();
            exp_q.delete();
        end else begin
            if (rec_pop) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                delivered++;
            end
            if (rec_push) begin
                exp_q.push_back(rec_val);
                accepted++;
            end
        end
        exp_empty = (exp_q.size() == 0);
        if (!exp_empty) exp_head = exp_q[0];
        rec_flush = i_flush || !g_resetn;
        rec_pop   = o_s3_valid && !i_s3_busy;
        rec_push  = i_s2_valid && !o_s2_busy;
        rec_val   = expect_out(i_s2);
    end

    // Checks --------------------
    a_out_expected: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_s3_valid && !i_s3_busy) |-> !exp_empty)
    else begin
        check_errors++;
        $display("Output transfer at %0t with no instruction outstanding", $time);
    end

    a_out_match: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_s3_valid && !i_s3_busy && !exp_empty) |-> (o_s3 == exp_head))
    else begin
        check_errors++;
        $display("Mismatch at %0t: o_s3 got %h expected %h", $time, $sampled(o_s3),
                 $sampled(exp_head));
    end

    a_fwd_match: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (i_s2_valid && !i_s2.fu[`FU_MUL]) |-> (o_fwd == fwd_exp))  // Mul result not yet formed
    else begin
        check_errors++;
        $display("Mismatch at %0t: o_fwd got %h expected %h", $time, $sampled(o_fwd),
                 $sampled(fwd_exp));
    end

    a_out_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_s3_valid && i_s3_busy && !i_flush) |=> (o_s3_valid && $stable(o_s3)))
    else begin
        check_errors++;
        $display("Output dropped or changed while blocked at %0t", $time);
    end

    a_reset_idle: assert property (@(posedge g_clk)
        !g_resetn |=> (!o_s3_valid && !o_s2_busy))
    else begin
        check_errors++;
        $display("Output valid or stage busy just after reset at %0t", $time);
    end

    // Downstream busy driver and watchdog
    initial begin
        i_s3_busy = 1'b0;
        forever begin
            @(posedge g_clk);
            #10;
            i_s3_busy = (busy_mode == 2'd2) || (busy_mode == 2'd1 && $urandom_range(0, 2) == 0);
        end
    end

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, stage stopped making progress", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Stimulus --------------------
    function automatic exec_pkg::word_t edge_word();
        case ($urandom_range(0, 5))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic exec_pkg::ex_in_t random_instr(int unit, logic allow_trap);
        exec_pkg::ex_in_t in;
        in.rd    = 5'($urandom);
        in.opr_a = $urandom;
        in.opr_b = $urandom;
        in.opr_c = $urandom;
        in.size  = 2'($urandom);
        in.instr = $urandom;
        in.trap  = allow_trap && ($urandom_range(0, 7) == 0);
        in.fu    = '0;
        in.fu[unit] = 1'b1;
        case (unit)
            `FU_ALU: in.uop = 5'($urandom_range(0, 9));
            `FU_MUL: begin
                in.uop   = 5'($urandom_range(0, 3));
                in.opr_a = edge_word();
                in.opr_b = edge_word();
            end
            `FU_LSU: in.uop = {($urandom_range(0, 1) == 1) ? 2'b10 : 2'b01, 3'($urandom)};
            `FU_CFU: begin
                case ($urandom_range(0, 7))
                    0:       in.uop = `CFU_BEQ;
                    1:       in.uop = `CFU_BNE;
                    2:       in.uop = `CFU_BLT;
                    3:       in.uop = `CFU_BGE;
                    4:       in.uop = `CFU_BLTU;
                    5:       in.uop = `CFU_BGEU;
                    6:       in.uop = `CFU_JAL;
                    default: in.uop = `CFU_JALR;
                endcase
                if ($urandom_range(0, 3) == 0) in.opr_b = in.opr_a;   // Hit the equal case
            end
            default: in.uop = 5'($urandom);
        endcase
        return in;
    endfunction

    task automatic next_cycle();
        @(posedge g_clk);
        #10;
    endtask

    task automatic send(input exec_pkg::ex_in_t in);
        logic accepted_now;
        i_s2         = in;
        i_s2_valid   = 1'b1;
        accepted_now = 1'b0;
        while (!accepted_now) begin
            @(negedge g_clk);
            accepted_now = !o_s2_busy;
            next_cycle();
        end
        i_s2_valid = 1'b0;
    endtask

    task automatic present_then_flush(input exec_pkg::ex_in_t in, input int wait_cycles);
        i_s2       = in;
        i_s2_valid = 1'b1;
        repeat (wait_cycles) next_cycle();
        i_s2_valid = 1'b0;                                          // Upstream cancels too
        i_flush    = 1'b1;
        next_cycle();
        i_flush    = 1'b0;
    endtask

    task automatic set_busy_mode(input logic [1:0] mode);
        @(negedge g_clk);
        busy_mode = mode;
        next_cycle();
    endtask

    task automatic apply_reset();
        g_resetn   = 1'b0;
        i_s2_valid = 1'b0;
        i_flush    = 1'b0;
        repeat (4) next_cycle();
        g_resetn   = 1'b1;
        next_cycle();                                               // One idle cycle to check
    endtask

    task automatic drain();
        i_s2_valid = 1'b0;
        repeat (2) next_cycle();
        while (exp_q.size() != 0) next_cycle();
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = check_errors + final_errors - err_mark;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %-16s %s, %0d check failures", name, (errs == 0) ? "ok" : "failed", errs);
        err_mark = check_errors + final_errors;
    endtask

    initial begin
        void'($urandom(48));
        i_s2 = '0;
        apply_reset();

        repeat (80) send(random_instr(`FU_ALU, 1'b0));
        drain();
        report_test("alu_random");

        repeat (60) send(random_instr(`FU_CFU, 1'b0));
        drain();
        report_test("branch_jump");

        repeat (60) send(random_instr(($urandom_range(0, 1) == 0) ? `FU_LSU : `FU_CSR, 1'b0));
        drain();
        report_test("lsu_csr");

        repeat (32) send(random_instr(`FU_MUL, 1'b0));
        drain();
        report_test("multiply_edges");

        set_busy_mode(2'd1);
        repeat (120) send(random_instr($urandom_range(0, 4), 1'b1));
        drain();
        set_busy_mode(2'd0);
        report_test("backpressure_trap");

        // Held output flushed, multiply aborted, reset while holding
        set_busy_mode(2'd2);
        send(random_instr(`FU_ALU, 1'b0));
        present_then_flush(random_instr(`FU_ALU, 1'b0), 3);
        set_busy_mode(2'd0);
        present_then_flush(random_instr(`FU_MUL, 1'b0), 12);
        repeat (6) send(random_instr($urandom_range(0, 4), 1'b1));
        drain();
        set_busy_mode(2'd2);
        send(random_instr(`FU_CSR, 1'b0));
        apply_reset();
        set_busy_mode(2'd0);
        repeat (4) send(random_instr($urandom_range(0, 4), 1'b0));
        drain();
        report_test("flush_reset");

        if (accepted != delivered + dropped) begin
            final_errors++;
            $display("Accepted %0d instructions but %0d left and %0d were dropped",
                     accepted, delivered, dropped);
        end
        $display("Tests %0d, failed %0d; accepted %0d, delivered %0d, dropped %0d; errors %0d",
                 tests_run, tests_failed, accepted, delivered, dropped,
                 check_errors + final_errors);
        if (check_errors + final_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_multiplier.sv
verilog/exec_result_select.sv
verilog/exec_pipe_reg.sv
verilog/exec_stage.sv
verif/tb_exec_stage.sv

// File: run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_exec_stage \
    -f flist.f -Mdir "$BUILD_DIR" -o tb_exec_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_exec_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
